// ==== hdl/gpio_control.sv ====
// Team select and pad multiplexer
`timescale 1ns/10ps

module gpio_control #(
    parameter int NUM_TEAMS = nebula_pkg::NUM_TEAMS_DEF
) (
    input  logic                                    wb_clk_i,
    input  logic                                    rst_n_i,
    wb_if.subordinate                               bus,
    input  logic [NUM_TEAMS*nebula_pkg::GPIO_W-1:0] team_out_flat_i,
    input  logic [NUM_TEAMS*nebula_pkg::GPIO_W-1:0] team_oeb_flat_i,
    output nebula_pkg::gpio_t                       io_out_o,
    output nebula_pkg::gpio_t                       io_oeb_o
);
    import nebula_pkg::*;

    reg_idx_t   idx;
    logic       req;
    logic       ack_q;
    logic [7:0] sel_q;
    gpio_t      pad_out;
    gpio_t      pad_oeb;

    assign idx = bus.adr[REG_IDX_LSB +: $bits(reg_idx_t)];
    assign req = bus.cyc & bus.stb & ~ack_q;

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // Team number lives in byte 0 only
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            sel_q <= '0;
        end else if (req && bus.we && bus.sel[0] && idx == REG_SEL) begin
            sel_q <= bus.dat_w[7:0];
        end
    end

    assign bus.ack   = ack_q;
    assign bus.dat_r = (idx == REG_SEL) ? {{(WB_DAT_W-8){1'b0}}, sel_q} : '0;

    // Select 0 or out of range leaves the pads as inputs
    always_comb begin
        pad_out = '0;
        pad_oeb = '1;
        for (int t = 0; t < NUM_TEAMS; t++) begin
            if (sel_q == 8'(t + 1)) begin
                pad_out = team_out_flat_i[t*GPIO_W +: GPIO_W];
                pad_oeb = team_oeb_flat_i[t*GPIO_W +: GPIO_W];
            end
        end
    end

    assign io_out_o = pad_out;
    assign io_oeb_o = pad_oeb;

endmodule

// ==== hdl/nebula_pkg.sv ====
// Nebula shared definitions
package nebula_pkg;

    // Bus and pad widths
    localparam int WB_ADR_W = 32;
    localparam int WB_DAT_W = 32;
    localparam int GPIO_W   = 32;

    // Team count used when the top level is not overridden
    localparam int NUM_TEAMS_DEF = 2;

    typedef logic [WB_ADR_W-1:0]   wb_adr_t;
    typedef logic [WB_DAT_W-1:0]   wb_data_t;
    typedef logic [WB_DAT_W/8-1:0] wb_sel_t;
    typedef logic [GPIO_W-1:0]     gpio_t;

    // Region field in address bits 15:12
    localparam int REGION_LSB = 12;
    localparam int REGION_W   = 4;

    // Register index in address bits 3:2
    localparam int REG_IDX_LSB = 2;
    typedef logic [1:0] reg_idx_t;

    // Team slot registers
    localparam reg_idx_t REG_OUT = 2'd0;
    localparam reg_idx_t REG_OEB = 2'd1;
    localparam reg_idx_t REG_IN  = 2'd2;

    // GPIO control registers
    localparam reg_idx_t REG_SEL = 2'd0;

endpackage

// ==== hdl/nebula_top.sv ====
// Nebula user area top level
`timescale 1ns/10ps

module nebula_top #(
    parameter int NUM_TEAMS = nebula_pkg::NUM_TEAMS_DEF
) (
    input  logic                 wb_clk_i,
    input  logic                 rst_n_i,

    // Wishbone slave port
    input  logic                 wbs_cyc_i,
    input  logic                 wbs_stb_i,
    input  logic                 wbs_we_i,
    input  nebula_pkg::wb_sel_t  wbs_sel_i,
    input  nebula_pkg::wb_adr_t  wbs_adr_i,
    input  nebula_pkg::wb_data_t wbs_dat_i,
    output logic                 wbs_ack_o,
    output nebula_pkg::wb_data_t wbs_dat_o,

    // Pads
    input  nebula_pkg::gpio_t    io_in_i,
    output nebula_pkg::gpio_t    io_out_o,
    output nebula_pkg::gpio_t    io_oeb_o
);
    import nebula_pkg::*;

    logic [NUM_TEAMS*GPIO_W-1:0] team_out_flat;
    logic [NUM_TEAMS*GPIO_W-1:0] team_oeb_flat;

    wb_if host_bus ();
    wb_if gpio_bus ();
    wb_if team_bus [NUM_TEAMS] ();

    // Host port into the decoder
    assign host_bus.cyc   = wbs_cyc_i;
    assign host_bus.stb   = wbs_stb_i;
    assign host_bus.we    = wbs_we_i;
    assign host_bus.sel   = wbs_sel_i;
    assign host_bus.adr   = wbs_adr_i;
    assign host_bus.dat_w = wbs_dat_i;
    assign wbs_ack_o      = host_bus.ack;
    assign wbs_dat_o      = host_bus.dat_r;

    wb_decoder #(
        .NUM_TEAMS(NUM_TEAMS)
    ) u_decoder (
        .wb_clk_i (wb_clk_i),
        .rst_n_i  (rst_n_i),
        .host     (host_bus.subordinate),
        .gpio_bus (gpio_bus.manager),
        .team_bus (team_bus)
    );

    gpio_control #(
        .NUM_TEAMS(NUM_TEAMS)
    ) u_gpio_control (
        .wb_clk_i        (wb_clk_i),
        .rst_n_i         (rst_n_i),
        .bus             (gpio_bus.subordinate),
        .team_out_flat_i (team_out_flat),
        .team_oeb_flat_i (team_oeb_flat),
        .io_out_o        (io_out_o),
        .io_oeb_o        (io_oeb_o)
    );

    // Every team sees the same input pins
    genvar k;
    generate
        for (k = 0; k < NUM_TEAMS; k++) begin : g_team
            team_slot u_team_slot (
                .wb_clk_i   (wb_clk_i),
                .rst_n_i    (rst_n_i),
                .bus        (team_bus[k]),
                .gpio_in_i  (io_in_i),
                .gpio_out_o (team_out_flat[k*GPIO_W +: GPIO_W]),
                .gpio_oeb_o (team_oeb_flat[k*GPIO_W +: GPIO_W])
            );
        end
    endgenerate

endmodule

// ==== hdl/team_slot.sv ====
// Team slot register block
`timescale 1ns/10ps

module team_slot (
    input  logic              wb_clk_i,
    input  logic              rst_n_i,
    wb_if.subordinate         bus,
    input  nebula_pkg::gpio_t gpio_in_i,
    output nebula_pkg::gpio_t gpio_out_o,
    output nebula_pkg::gpio_t gpio_oeb_o
);
    import nebula_pkg::*;

    reg_idx_t idx;
    logic     req;
    logic     wr;
    logic     ack_q;
    gpio_t    out_q;
    gpio_t    oeb_q;
    gpio_t    in_meta_q;
    gpio_t    in_sync_q;
    wb_data_t rd_data;

    assign idx = bus.adr[REG_IDX_LSB +: $bits(reg_idx_t)];
    assign req = bus.cyc & bus.stb & ~ack_q;
    assign wr  = req & bus.we;

    // Single-cycle ack one clock after the request
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    // Byte-writable output and enable words
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            out_q <= '0;
            oeb_q <= '1;
        end else if (wr) begin
            for (int b = 0; b < GPIO_W / 8; b++) begin
                if (bus.sel[b] && idx == REG_OUT) begin
                    out_q[8*b +: 8] <= bus.dat_w[8*b +: 8];
                end
                if (bus.sel[b] && idx == REG_OEB) begin
                    oeb_q[8*b +: 8] <= bus.dat_w[8*b +: 8];
                end
            end
        end
    end

    // Pads are asynchronous to the bus clock
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            in_meta_q <= '0;
            in_sync_q <= '0;
        end else begin
            in_meta_q <= gpio_in_i;
            in_sync_q <= in_meta_q;
        end
    end

    always_comb begin
        case (idx)
            REG_OUT: rd_data = out_q;
            REG_OEB: rd_data = oeb_q;
            REG_IN:  rd_data = in_sync_q;
            default: rd_data = '0;
        endcase
    end

    assign bus.ack    = ack_q;
    assign bus.dat_r  = rd_data;
    assign gpio_out_o = out_q;
    assign gpio_oeb_o = oeb_q;

endmodule

// ==== hdl/wb_decoder.sv ====
// Wishbone region decoder
`timescale 1ns/10ps

module wb_decoder #(
    parameter int NUM_TEAMS = nebula_pkg::NUM_TEAMS_DEF
) (
    input  logic      wb_clk_i,
    input  logic      rst_n_i,
    wb_if.subordinate host,
    wb_if.manager     gpio_bus,
    wb_if.manager     team_bus [NUM_TEAMS]
);
    import nebula_pkg::*;

    logic [REGION_W-1:0]  region;
    logic                 gpio_hit;
    logic [NUM_TEAMS-1:0] team_hit;
    logic                 unmapped;
    logic                 unmapped_ack_q;
    logic [NUM_TEAMS-1:0] team_ack;
    wb_data_t             team_dat [NUM_TEAMS];
    wb_data_t             dat_mux;

    assign region   = host.adr[REGION_LSB +: REGION_W];
    assign gpio_hit = (region == '0);
    assign unmapped = ~gpio_hit & ~(|team_hit);

    // Region 0 goes to GPIO control
    assign gpio_bus.cyc   = host.cyc & gpio_hit;
    assign gpio_bus.stb   = host.stb & gpio_hit;
    assign gpio_bus.we    = host.we;
    assign gpio_bus.sel   = host.sel;
    assign gpio_bus.adr   = host.adr;
    assign gpio_bus.dat_w = host.dat_w;

    // Region k+1 goes to team slot k
    genvar k;
    generate
        for (k = 0; k < NUM_TEAMS; k++) begin : g_team
            assign team_hit[k]        = (region == REGION_W'(k + 1));
            assign team_bus[k].cyc    = host.cyc & team_hit[k];
            assign team_bus[k].stb    = host.stb & team_hit[k];
            assign team_bus[k].we     = host.we;
            assign team_bus[k].sel    = host.sel;
            assign team_bus[k].adr    = host.adr;
            assign team_bus[k].dat_w  = host.dat_w;
            assign team_ack[k]        = team_bus[k].ack;
            assign team_dat[k]        = team_bus[k].dat_r;
        end
    endgenerate

    // Unmapped regions get a local ack and drop writes
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            unmapped_ack_q <= 1'b0;
        end else begin
            unmapped_ack_q <= host.cyc & host.stb & unmapped & ~unmapped_ack_q;
        end
    end

    // Read data follows the addressed target, zero when unmapped
    always_comb begin
        dat_mux = '0;
        if (gpio_hit) begin
            dat_mux = gpio_bus.dat_r;
        end
        for (int i = 0; i < NUM_TEAMS; i++) begin
            if (team_hit[i]) begin
                dat_mux = team_dat[i];
            end
        end
    end

    // Only the addressed target sees stb, so a plain OR is enough
    assign host.ack   = gpio_bus.ack | (|team_ack) | unmapped_ack_q;
    assign host.dat_r = dat_mux;

endmodule

// ==== hdl/wb_if.sv ====
// Classic Wishbone bus
`timescale 1ns/10ps

interface wb_if;
    import nebula_pkg::*;

    logic     cyc;
    logic     stb;
    logic     we;
    wb_sel_t  sel;
    wb_adr_t  adr;
    wb_data_t dat_w;
    wb_data_t dat_r;
    logic     ack;

    // Side that starts cycles
    modport manager (
        output cyc, stb, we, sel, adr, dat_w,
        input  dat_r, ack
    );

    // Side that answers with ack and read data
    modport subordinate (
        input  cyc, stb, we, sel, adr, dat_w,
        output dat_r, ack
    );

endinterface

// ==== list.f ====
hdl/nebula_pkg.sv
hdl/wb_if.sv
hdl/wb_decoder.sv
hdl/team_slot.sv
hdl/gpio_control.sv
hdl/nebula_top.sv
verif/nebula_tb.sv

// ==== verif/nebula_tb.sv ====
// Nebula user area testbench
`timescale 1ns/10ps

module nebula_tb;
    import nebula_pkg::*;

    localparam int NUM_TEAMS   = 2;
    localparam int ACK_TIMEOUT = 20;
    localparam int POLL_LIMIT  = 10;

    logic     wb_clk_i;
    logic     rst_n_i;
    logic     wbs_cyc_i;
    logic     wbs_stb_i;
    logic     wbs_we_i;
    wb_sel_t  wbs_sel_i;
    wb_adr_t  wbs_adr_i;
    wb_data_t wbs_dat_i;
    logic     wbs_ack_o;
    wb_data_t wbs_dat_o;
    gpio_t    io_in_i;
    gpio_t    io_out_o;
    gpio_t    io_oeb_o;

    integer   seed;
    int       errors;
    int       checks;

    // Software model of every team's output and enable words
    wb_data_t exp_out [1:NUM_TEAMS];
    wb_data_t exp_oeb [1:NUM_TEAMS];

    nebula_top #(
        .NUM_TEAMS(NUM_TEAMS)
    ) dut_i (
        .wb_clk_i  (wb_clk_i),
        .rst_n_i   (rst_n_i),
        .wbs_cyc_i (wbs_cyc_i),
        .wbs_stb_i (wbs_stb_i),
        .wbs_we_i  (wbs_we_i),
        .wbs_sel_i (wbs_sel_i),
        .wbs_adr_i (wbs_adr_i),
        .wbs_dat_i (wbs_dat_i),
        .wbs_ack_o (wbs_ack_o),
        .wbs_dat_o (wbs_dat_o),
        .io_in_i   (io_in_i),
        .io_out_o  (io_out_o),
        .io_oeb_o  (io_oeb_o)
    );

    initial begin
        wb_clk_i = 1'b0;
        forever #50 wb_clk_i = ~wb_clk_i;
    end

    function automatic wb_adr_t reg_addr(input int region, input reg_idx_t idx);
        wb_adr_t adr;
        adr = '0;
        adr[REGION_LSB +: 4] = region[3:0];
        adr[REG_IDX_LSB +: 2] = idx;
        return adr;
    endfunction

    // Byte lanes with sel set take the new data
    function automatic wb_data_t merge_bytes(input wb_data_t old_w, input wb_data_t new_w,
                                             input wb_sel_t sel);
        wb_data_t res;
        res = old_w;
        for (int b = 0; b < WB_DAT_W / 8; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_w[8*b +: 8];
            end
        end
        return res;
    endfunction

    task automatic finish_run();
        $display("Closing: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input wb_data_t got, input wb_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_gpio(input string name, input gpio_t got, input gpio_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    // One classic cycle with ack sampled on the falling edge
    task automatic wb_access(input logic we, input wb_adr_t adr, input wb_data_t wdat,
                             input wb_sel_t sel, output wb_data_t rdat);
        int waited;
        waited = 0;
        @(posedge wb_clk_i);
        wbs_cyc_i <= 1'b1;
        wbs_stb_i <= 1'b1;
        wbs_we_i  <= we;
        wbs_adr_i <= adr;
        wbs_dat_i <= wdat;
        wbs_sel_i <= sel;
        @(negedge wb_clk_i);
        while (!wbs_ack_o && waited < ACK_TIMEOUT) begin
            waited++;
            @(negedge wb_clk_i);
        end
        if (!wbs_ack_o) begin
            errors++;
            $display("No ack for the access to address %h", adr);
            finish_run();
        end else begin
            checks++;
            if (waited != 1) begin
                errors++;
                $display("Ack at address %h came after %0d cycles instead of 1", adr, waited);
            end
            rdat = wbs_dat_o;
            @(posedge wb_clk_i);
            wbs_cyc_i <= 1'b0;
            wbs_stb_i <= 1'b0;
            wbs_we_i  <= 1'b0;
            @(negedge wb_clk_i);
            if (wbs_ack_o) begin
                errors++;
                $display("Ack at address %h stayed high for more than one cycle", adr);
            end
        end
    endtask

    task automatic wb_write(input wb_adr_t adr, input wb_data_t data, input wb_sel_t sel);
        wb_data_t unused;
        wb_access(1'b1, adr, data, sel, unused);
    endtask

    task automatic wb_read(input wb_adr_t adr, output wb_data_t data);
        wb_access(1'b0, adr, '0, '1, data);
    endtask

    task automatic reset_defaults();
        wb_data_t rd;
        @(negedge wb_clk_i);
        check_flag("wbs_ack_o", wbs_ack_o, 1'b0);
        check_gpio("io_out_o", io_out_o, '0);
        check_gpio("io_oeb_o", io_oeb_o, '1);
        wb_read(reg_addr(0, REG_SEL), rd);
        check_data("REG_SEL", rd, '0);
    endtask

    task automatic register_readback();
        wb_data_t rd;
        for (int t = 1; t <= NUM_TEAMS; t++) begin
            exp_out[t] = $random(seed);
            exp_oeb[t] = $random(seed);
            wb_write(reg_addr(t, REG_OUT), exp_out[t], '1);
            wb_write(reg_addr(t, REG_OEB), exp_oeb[t], '1);
            wb_read(reg_addr(t, REG_OUT), rd);
            check_data($sformatf("team%0d REG_OUT", t), rd, exp_out[t]);
            wb_read(reg_addr(t, REG_OEB), rd);
            check_data($sformatf("team%0d REG_OEB", t), rd, exp_oeb[t]);
            // io_in_i is still zero here
            wb_write(reg_addr(t, REG_IN), $random(seed), '1);
            wb_read(reg_addr(t, REG_IN), rd);
            check_data($sformatf("team%0d REG_IN", t), rd, '0);
            wb_write(reg_addr(t, 2'd3), $random(seed), '1);
            wb_read(reg_addr(t, 2'd3), rd);
            check_data($sformatf("team%0d index 3", t), rd, '0);
        end
    endtask

    task automatic byte_select_writes();
        wb_data_t rd;
        wb_data_t wdat;
        wdat = $random(seed);
        wb_write(reg_addr(1, REG_OUT), wdat, 4'b0101);
        exp_out[1] = merge_bytes(exp_out[1], wdat, 4'b0101);
        wb_read(reg_addr(1, REG_OUT), rd);
        check_data("team1 REG_OUT", rd, exp_out[1]);
        wdat = $random(seed);
        wb_write(reg_addr(2, REG_OEB), wdat, 4'b1010);
        exp_oeb[2] = merge_bytes(exp_oeb[2], wdat, 4'b1010);
        wb_read(reg_addr(2, REG_OEB), rd);
        check_data("team2 REG_OEB", rd, exp_oeb[2]);
    endtask

    task automatic pad_routing();
        wb_data_t rd;
        for (int s = 1; s <= NUM_TEAMS; s++) begin
            wb_write(reg_addr(0, REG_SEL), s, 4'b0001);
            check_gpio($sformatf("io_out_o sel %0d", s), io_out_o, exp_out[s]);
            check_gpio($sformatf("io_oeb_o sel %0d", s), io_oeb_o, exp_oeb[s]);
            wb_read(reg_addr(0, REG_SEL), rd);
            check_data("REG_SEL", rd, s);
        end
        // Select 0 and out of range park the pads
        wb_write(reg_addr(0, REG_SEL), 0, 4'b0001);
        check_gpio("io_out_o sel 0", io_out_o, '0);
        check_gpio("io_oeb_o sel 0", io_oeb_o, '1);
        wb_write(reg_addr(0, REG_SEL), 3, 4'b0001);
        check_gpio("io_out_o sel 3", io_out_o, '0);
        check_gpio("io_oeb_o sel 3", io_oeb_o, '1);
    endtask

    task automatic input_sync_readback();
        wb_data_t rd;
        gpio_t    pins;
        int       polls;
        pins = $random(seed);
        @(posedge wb_clk_i);
        io_in_i <= pins;
        for (int t = 1; t <= NUM_TEAMS; t++) begin
            polls = 0;
            wb_read(reg_addr(t, REG_IN), rd);
            while (rd !== pins && polls < POLL_LIMIT) begin
                polls++;
                wb_read(reg_addr(t, REG_IN), rd);
            end
            check_data($sformatf("team%0d REG_IN", t), rd, pins);
        end
    endtask

    task automatic unmapped_region();
        wb_data_t rd;
        wb_write(reg_addr(5, REG_OUT), $random(seed), '1);
        wb_read(reg_addr(5, REG_OUT), rd);
        check_data("region 5 read", rd, '0);
        for (int t = 1; t <= NUM_TEAMS; t++) begin
            wb_read(reg_addr(t, REG_OUT), rd);
            check_data($sformatf("team%0d REG_OUT", t), rd, exp_out[t]);
            wb_read(reg_addr(t, REG_OEB), rd);
            check_data($sformatf("team%0d REG_OEB", t), rd, exp_oeb[t]);
        end
    endtask

    initial begin
        seed      = 29;
        errors    = 0;
        checks    = 0;
        rst_n_i   = 1'b0;
        wbs_cyc_i = 1'b0;
        wbs_stb_i = 1'b0;
        wbs_we_i  = 1'b0;
        wbs_sel_i = '0;
        wbs_adr_i = '0;
        wbs_dat_i = '0;
        io_in_i   = '0;
        repeat (3) @(posedge wb_clk_i);
        rst_n_i <= 1'b1;
        reset_defaults();
        register_readback();
        byte_select_writes();
        pad_routing();
        input_sync_readback();
        unmapped_region();
        finish_run();
    end

endmodule
